/* source/dog_pkg.sv */
package dog_pkg;

  // frame geometry, kept small for simulation.
  localparam int COLS         = 16;
  localparam int ROWS         = 8;
  localparam int PIX_W        = 8;
  localparam int LAYERS       = 4;
  localparam int CONTRAST_MIN = 4;

  typedef logic signed [PIX_W-1:0]      pixel_t;
  // column c occupies bits c*PIX_W upward.
  typedef logic        [COLS*PIX_W-1:0] row_t;
  typedef logic        [3:0]            col_t;
  typedef logic        [2:0]            row_idx_t;
  // saturates at 63.
  typedef logic        [5:0]            kp_count_t;

  typedef struct packed {
    row_t layer0;
    row_t layer1;
    row_t layer2;
    row_t layer3;
  } dog_beat_t;

  // index [n] of each row array is DoG layer n.
  typedef struct packed {
    row_t [LAYERS-1:0] top;
    row_t [LAYERS-1:0] mid;
    row_t [LAYERS-1:0] bot;
    row_idx_t          mid_row;
  } window_t;

  typedef struct packed {
    row_idx_t row;
    col_t     col;
    logic     scale;   // 0 is scale 1, 1 is scale 2.
  } keypoint_t;

  typedef struct packed {
    kp_count_t total;
  } frame_report_t;

  typedef enum logic [1:0] {
    scan_idle,
    scan_detect,
    scan_second,
    scan_row_end
  } scan_state_t;

endpackage

/* source/dog_row_window.sv */
module dog_row_window
  import dog_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  dog_beat_t in_beat,
  output logic      window_valid,
  input  logic      window_ack,
  output window_t   window
);

  row_t [LAYERS-1:0] beat_rows;
  row_idx_t          row_cnt_q;
  window_t           win_q;
  logic              accept;
  logic              completes_window;

  assign beat_rows = {in_beat.layer3, in_beat.layer2, in_beat.layer1, in_beat.layer0};
  assign accept    = in_valid && in_ready;
  assign window    = win_q;

  // from row 2 on, the middle row of the window is an interior row.
  assign completes_window = accept && (row_cnt_q >= row_idx_t'(2));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt_q <= '0;
    end else if (accept) begin
      if (row_cnt_q == row_idx_t'(ROWS - 1)) begin
        row_cnt_q <= '0;
      end else begin
        row_cnt_q <= row_cnt_q + 1'b1;
      end
    end
  end

  // input stalls while a full window waits for the scanner.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window_valid <= 1'b0;
      in_ready     <= 1'b1;
    end else if (completes_window) begin
      window_valid <= 1'b1;
      in_ready     <= 1'b0;
    end else if (window_ack) begin
      window_valid <= 1'b0;
      in_ready     <= 1'b1;
    end
  end

  // rows shift down by one on every accepted beat.
  always_ff @(posedge clk) begin
    if (accept) begin
      win_q.top     <= win_q.mid;
      win_q.mid     <= win_q.bot;
      win_q.bot     <= beat_rows;
      win_q.mid_row <= row_cnt_q - 1'b1;
    end
  end

  a_one_row_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(in_ready && window_valid)
  ) else $error("row window accepts a beat while a window is pending");

endmodule

/* source/extremum_test.sv */
module extremum_test
  import dog_pkg::*;
(
  input  window_t window,
  input  col_t    col,
  input  logic    base_layer,
  output logic    hit
);

  // 3 layers x 3 rows x 3 columns; index 13 is the centre sample.
  pixel_t nb [27];
  pixel_t centre;
  logic   is_max;
  logic   is_min;
  logic   contrast_ok;

  function automatic pixel_t pix_at(row_t r, int c);
    return pixel_t'(r[c*PIX_W +: PIX_W]);
  endfunction

  always_comb begin
    int c;
    int lyr;
    for (int l = 0; l < 3; l++) begin
      lyr = int'(base_layer) + l;
      for (int d = 0; d < 3; d++) begin
        c = int'(col) - 1 + d;
        nb[l*9 + d]     = pix_at(window.top[lyr], c);
        nb[l*9 + 3 + d] = pix_at(window.mid[lyr], c);
        nb[l*9 + 6 + d] = pix_at(window.bot[lyr], c);
      end
    end
  end

  assign centre = nb[13];

  // a tie with any neighbour fails both tests.
  always_comb begin
    is_max = 1'b1;
    is_min = 1'b1;
    for (int i = 0; i < 27; i++) begin
      if (i != 13) begin
        if (!(centre > nb[i])) is_max = 1'b0;
        if (!(centre < nb[i])) is_min = 1'b0;
      end
    end
  end

  assign contrast_ok = (centre >= CONTRAST_MIN) || (centre <= -CONTRAST_MIN);

  assign hit = (is_max || is_min) && contrast_ok;

endmodule

/* source/extremum_scan.sv */
module extremum_scan
  import dog_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      window_valid,
  input  window_t   window,
  output logic      window_ack,
  output col_t      col,
  input  logic      hit1,
  input  logic      hit2,
  output logic      rec_valid,
  input  logic      rec_ready,
  output keypoint_t rec,
  output logic      frame_last
);

  scan_state_t state_q;
  scan_state_t state_d;
  col_t        col_q;
  col_t        col_d;
  logic        any_hit;
  logic        both_hit;
  logic        col_done;
  logic        step;

  assign any_hit  = hit1 || hit2;
  assign both_hit = hit1 && hit2;
  assign col_done = (col_q == col_t'(COLS - 2));

  // leave the column once its last record has been taken.
  always_comb begin
    step = 1'b0;
    case (state_q)
      scan_detect: step = !any_hit || (rec_ready && !both_hit);
      scan_second: step = rec_ready;
      default:     step = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    col_d   = col_q;
    case (state_q)
      scan_idle: begin
        if (window_valid) begin
          state_d = scan_detect;
        end
      end
      scan_detect, scan_second: begin
        if (step) begin
          if (col_done) begin
            state_d = scan_row_end;
          end else begin
            state_d = scan_detect;
            col_d   = col_q + 1'b1;
          end
        end else if (state_q == scan_detect && both_hit && rec_ready) begin
          state_d = scan_second;
        end
      end
      scan_row_end: begin
        state_d = scan_idle;
        col_d   = col_t'(1);
      end
      default: begin
        state_d = scan_idle;
        col_d   = col_t'(1);
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= scan_idle;
      col_q   <= col_t'(1);
    end else begin
      state_q <= state_d;
      col_q   <= col_d;
    end
  end

  assign col = col_q;

  // scale 1 goes first when both scales hit.
  assign rec_valid = (state_q == scan_detect && any_hit) || (state_q == scan_second);
  assign rec.row   = window.mid_row;
  assign rec.col   = col_q;
  assign rec.scale = (state_q == scan_second) || !hit1;

  assign window_ack = (state_q == scan_row_end);
  assign frame_last = window_ack && (window.mid_row == row_idx_t'(ROWS - 2));

  a_col_interior: assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q == scan_detect |-> (col_q >= col_t'(1)) && (col_q <= col_t'(COLS - 2))
  ) else $error("scan column left the interior range");

endmodule

/* source/keypoint_out.sv */
module keypoint_out
  import dog_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          rec_valid,
  output logic          rec_ready,
  input  keypoint_t     rec,
  input  logic          frame_last,
  output logic          out_valid,
  input  logic          out_ready,
  output keypoint_t     out_kp,
  output logic          report_valid,
  output frame_report_t report
);

  keypoint_t mem_q [2];
  logic      wr_ptr_q;
  logic      rd_ptr_q;
  logic [1:0] count_q;
  kp_count_t kp_cnt_q;
  logic      pending_q;
  logic      push;
  logic      pop;

  assign rec_ready = (count_q != 2'd2);
  assign out_valid = (count_q != 2'd0);
  assign out_kp    = mem_q[rd_ptr_q];
  assign push      = rec_valid && rec_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rec;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= !wr_ptr_q;
      if (pop) rd_ptr_q <= !rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  // the report waits for the frame's records to drain.
  assign report_valid = pending_q && (count_q == 2'd0);
  assign report.total = kp_cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
      kp_cnt_q  <= '0;
    end else begin
      if (frame_last) begin
        pending_q <= 1'b1;
      end else if (report_valid) begin
        pending_q <= 1'b0;
      end
      if (report_valid) begin
        kp_cnt_q <= push ? kp_count_t'(1) : '0;
      end else if (push && kp_cnt_q != '1) begin
        kp_cnt_q <= kp_cnt_q + 1'b1;
      end
    end
  end

  a_out_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_kp)
  ) else $error("out_kp changed while stalled");

endmodule

/* source/dog_keypoint_top.sv */
module dog_keypoint_top
  import dog_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          in_valid,
  output logic          in_ready,
  input  dog_beat_t     in_beat,
  output logic          out_valid,
  input  logic          out_ready,
  output keypoint_t     out_kp,
  output logic          report_valid,
  output frame_report_t report
);

  window_t   window;
  logic      window_valid;
  logic      window_ack;
  col_t      col;
  logic      hit1;
  logic      hit2;
  logic      rec_valid;
  logic      rec_ready;
  keypoint_t rec;
  logic      frame_last;

  dog_row_window dog_row_window_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_beat      (in_beat),
    .window_valid (window_valid),
    .window_ack   (window_ack),
    .window       (window)
  );

  // scale 1 looks at layers 0..2, scale 2 at layers 1..3.
  extremum_test extremum_test_s1_i (
    .window     (window),
    .col        (col),
    .base_layer (1'b0),
    .hit        (hit1)
  );

  extremum_test extremum_test_s2_i (
    .window     (window),
    .col        (col),
    .base_layer (1'b1),
    .hit        (hit2)
  );

  extremum_scan extremum_scan_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .window_valid (window_valid),
    .window       (window),
    .window_ack   (window_ack),
    .col          (col),
    .hit1         (hit1),
    .hit2         (hit2),
    .rec_valid    (rec_valid),
    .rec_ready    (rec_ready),
    .rec          (rec),
    .frame_last   (frame_last)
  );

  keypoint_out keypoint_out_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .rec_valid    (rec_valid),
    .rec_ready    (rec_ready),
    .rec          (rec),
    .frame_last   (frame_last),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_kp       (out_kp),
    .report_valid (report_valid),
    .report       (report)
  );

endmodule

/* dv/tb_dog_keypoint.sv */
module tb_dog_keypoint
  import dog_pkg::*;
();

  logic          clk;
  logic          rst_n;
  logic          in_valid;
  logic          in_ready;
  dog_beat_t     in_beat;
  logic          out_valid;
  logic          out_ready;
  keypoint_t     out_kp;
  logic          report_valid;
  frame_report_t report;

  dog_beat_t     beats [$];
  keypoint_t     exp_kp [$];
  kp_count_t     exp_total [$];
  int            exp_count [$];
  frame_report_t exp_rep;
  int            frames_done;
  int            seen_in_frame;
  int            cycle_cnt;
  int            cycle_limit;

  dog_keypoint_top dog_keypoint_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_beat      (in_beat),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_kp       (out_kp),
    .report_valid (report_valid),
    .report       (report)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_keypoint(input keypoint_t got, input keypoint_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: keypoint row %0d col %0d scale %0d, expected %0d %0d %0d",
                          $time, got.row, got.col, got.scale, exp.row, exp.col, exp.scale));
    end
  endtask

  task automatic check_report(input frame_report_t got, input frame_report_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: frame %0d reported total %0d, expected %0d",
                          $time, frames_done, got.total, exp.total));
    end
  endtask

  // one frame is eight row lines, its keypoint lines and an end line.
  task automatic load_cases();
    int        fd;
    int        n;
    int        rows_seen;
    int        kps_seen;
    int        kp_row;
    int        kp_col;
    int        kp_scale;
    int        total;
    string     line;
    byte       tag;
    row_t      l0;
    row_t      l1;
    row_t      l2;
    row_t      l3;
    dog_beat_t beat;
    keypoint_t kp;
    rows_seen = 0;
    kps_seen  = 0;
    fd = $fopen("dv/keypoint_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the case file dv/keypoint_cases.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      tag = line.getc(0);
      if (tag == "r") begin
        n = $sscanf(line, "row %h %h %h %h", l0, l1, l2, l3);
        if (n != 4) begin
          abort_run("a row line in the case file does not hold four layers");
        end
        beat.layer0 = l0;
        beat.layer1 = l1;
        beat.layer2 = l2;
        beat.layer3 = l3;
        beats.push_back(beat);
        rows_seen++;
      end else if (tag == "k") begin
        n = $sscanf(line, "kp %d %d %d", kp_row, kp_col, kp_scale);
        if (n != 3) begin
          abort_run("a keypoint line in the case file is incomplete");
        end
        kp.row   = row_idx_t'(kp_row);
        kp.col   = col_t'(kp_col);
        kp.scale = (kp_scale != 0);
        exp_kp.push_back(kp);
        kps_seen++;
      end else if (tag == "e") begin
        n = $sscanf(line, "end %d", total);
        if (n != 1 || rows_seen != ROWS) begin
          abort_run("a frame in the case file has a bad end line or the wrong row count");
        end
        exp_total.push_back(kp_count_t'(total));
        exp_count.push_back(kps_seen);
        rows_seen = 0;
        kps_seen  = 0;
      end else begin
        abort_run("the case file holds a line that is not row, kp or end");
      end
    end
    $fclose(fd);
    if (exp_total.size() == 0 || rows_seen != 0) begin
      abort_run("the case file has no complete frame or ends inside a frame");
    end
  endtask

  task automatic drive_rows();
    int idx;
    idx = 0;
    while (idx < beats.size()) begin
      @(posedge clk);
      #1;
      in_valid = ($urandom % 5) != 0;
      in_beat  = beats[idx];
      @(negedge clk);
      if (in_valid && in_ready) begin
        idx++;
      end
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  // roughly a quarter of cycles stall the output.
  task automatic toggle_out_ready();
    forever begin
      @(posedge clk);
      #1;
      out_ready = ($urandom % 4) != 0;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid && out_ready) begin
        if (exp_kp.size() == 0) begin
          abort_run($sformatf("keypoint at row %0d col %0d came out but none was expected",
                              out_kp.row, out_kp.col));
        end else begin
          check_keypoint(out_kp, exp_kp.pop_front());
          seen_in_frame++;
        end
      end
      if (report_valid) begin
        if (frames_done >= exp_total.size()) begin
          abort_run("a frame report arrived after the last frame");
        end else if (seen_in_frame != exp_count[frames_done]) begin
          abort_run($sformatf("frame %0d was reported with %0d of its %0d keypoints out",
                              frames_done, seen_in_frame, exp_count[frames_done]));
        end else begin
          exp_rep.total = exp_total[frames_done];
          check_report(report, exp_rep);
          frames_done++;
          seen_in_frame = 0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("run timed out after %0d cycles", cycle_cnt));
    end
  end

  initial begin
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_beat       = '0;
    out_ready     = 1'b0;
    exp_rep       = '0;
    frames_done   = 0;
    seen_in_frame = 0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    void'($urandom(13412));
    load_cases();
    cycle_limit = exp_total.size() * ROWS * 4 * (COLS + 4) + 200;
    repeat (16) @(posedge clk);
    #1;
    if (!in_ready || out_valid || report_valid) begin
      abort_run("the DUT outputs are not in their reset state");
    end
    rst_n = 1'b1;
    fork
      drive_rows();
      toggle_out_ready();
    join_none
    while (frames_done < exp_total.size()) begin
      @(posedge clk);
    end
    // a few more cycles catch stray records.
    repeat (20) @(posedge clk);
    #1;
    if (in_ready && !out_valid && !report_valid) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("the DUT did not return to idle after the last frame");
    end
  end

endmodule

/* dv/keypoint_cases.txt */
# row: layer0 layer1 layer2 layer3 as hex rows, column c in bits c*8 up.
# kp: row col scale (0 is scale 1, 1 is scale 2); end: expected frame total.
# single maximum at scale 1.
row 0 0 0 0
row 0 0 0 0
row 0 0 0 0
row 0 14000000000000 0 0
row 0 0 0 0
row 0 0 0 0
row 0 0 0 0
row 0 0 0 0
kp 3 6 0
end 1
# minimum at scale 2.
row 0 0 0 0
row 0 0 0 0
row 0 0 0 0
row 0 0 0 0
row 0 0 fa000000000000000000 0
row 0 0 0 0
row 0 0 0 0
row 0 0 0 0
kp 4 9 1
end 1
# low contrast, a tie in one layer and a tie across layers.
row 0 0 0 0
row 0 0 0 0
row 0 300000000 0 0
row 0 0 0 0
row 30000000000000000000000000 30000000000000000000000000 0 0
row 0 19190000000000000000 0 0
row 0 0 0 0
row 0 0 0 0
end 0
# border peaks plus one interior maximum.
row 0 200000000000 0 0
row 0 0 0 0
row 0 0 0 0
row 0 20 0 0
row 0 0 30000000000000000000000000000000 0
row 0 c000000000000 0 0
row 0 0 0 0
row 0 0 2000000000000000000000 0
kp 5 6 0
end 1
# both scales at one position and several keypoints.
row 0 0 0 0
row 0 700000000000000000000 0 0
row 0 a00000000000000 1100000000f600000000000000 0
row 0 0 0 0
row 0 8000000000000e0000000 0 0
row 0 0 0 0
row 0 0 50000000000000000000000000000 0
row 0 0 0 0
kp 1 10 0
kp 2 7 0
kp 2 7 1
kp 2 12 1
kp 4 3 0
kp 4 10 0
kp 6 14 1
end 7
# contrast exactly at the limit and full-range values.
row 0 0 0 0
row 0 0 0 0
row 0 40000000000 0 0
row 0 800000000000000000000000000000 0 0
row 0 0 0 0
row 0 0 7f00 0
row 0 fc000000000000000000 0 0
row 0 0 0 0
kp 2 5 0
kp 3 14 0
kp 5 1 1
kp 6 9 0
end 4

/* all.f */
source/dog_pkg.sv
source/dog_row_window.sv
source/extremum_test.sv
source/extremum_scan.sv
source/keypoint_out.sv
source/dog_keypoint_top.sv
dv/tb_dog_keypoint.sv

/* Makefile */
TOP = tb_dog_keypoint

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
